//--- bench/wb_stim.txt
# name fu uop opr_a opr_b rd size trap dmem_error dmem_rdata csr_rdata csr_error (hex)
# then gpr_wen gpr_wdata cf_req cf_target trap_cause, jump rows link to the tracked PC
alu_add     01 00 1234abcd 00000000 05 2 0 0 00000000 00000000 0 1 1234abcd 0 00000000 00
mul_lo      02 00 fffe0001 00000000 0a 2 0 0 00000000 00000000 0 1 fffe0001 0 00000000 00
sw_ok       04 16 0000000f 00002000 00 2 0 0 00000000 00000000 0 0 00000000 0 00000000 00
lb_o0       04 0b 00000001 00002000 06 2 0 0 8a7bc6f5 00000000 0 1 fffffff5 0 00000000 00
lbu_o1      04 0a 00000002 00002001 07 1 0 0 8a7bc6f5 00000000 0 1 000000c6 0 00000000 00
lb_o2       04 0b 00000004 00002002 08 2 0 0 8a7bc6f5 00000000 0 1 0000007b 0 00000000 00
lb_o3       04 0b 00000008 00002003 09 2 0 0 8a7bc6f5 00000000 0 1 ffffff8a 0 00000000 00
lh_o0       04 0d 00000003 00002000 0b 2 0 0 8a7bc6f5 00000000 0 1 ffffc6f5 0 00000000 00
lhu_o2      04 0c 0000000c 00002002 0c 2 0 0 8a7bc6f5 00000000 0 1 00008a7b 0 00000000 00
lh_o2       04 0d 0000000c 00002002 0c 2 0 0 8a7bc6f5 00000000 0 1 ffff8a7b 0 00000000 00
lw_o0       04 0e 0000000f 00002000 0d 2 0 0 8a7bc6f5 00000000 0 1 8a7bc6f5 0 00000000 00
lw_err      04 0e 0000000f 00002004 0e 2 0 1 deadbeef 00000000 0 0 00000000 1 80000100 05
sw_err      04 16 0000000f 00002008 00 2 0 1 00000000 00000000 0 0 00000000 1 80000100 07
csr_rd      10 10 00000000 00000300 0f 2 0 0 00000000 12345678 0 1 12345678 0 00000000 00
csr_rw      10 18 000000aa 00000341 10 2 0 0 00000000 00000055 0 1 00000055 0 00000000 00
csr_err     10 10 00000000 00000fff 11 2 0 0 00000000 00000001 1 0 00000000 1 80000100 02
jal         08 02 80000200 00000000 01 2 0 0 00000000 00000000 0 1 00000000 1 80000200 00
jalr_c      08 03 80000300 00000000 01 1 0 0 00000000 00000000 0 1 00000000 1 80000300 00
beq_tk      08 01 80000400 00000000 00 2 0 0 00000000 00000000 0 0 00000000 1 80000400 00
mret        08 06 00000000 00000000 00 2 0 0 00000000 00000000 0 0 00000000 1 80001000 00
ecall       08 05 00000000 00000000 00 2 0 0 00000000 00000000 0 0 00000000 1 80000100 0b
ebreak      08 04 00000000 00000000 00 1 0 0 00000000 00000000 0 0 00000000 1 80000100 03
flt_ldal    01 00 11111111 00003001 04 2 1 0 00000000 00000000 0 0 00000000 1 80000100 04
flt_iacc    01 00 00000000 00000000 01 2 1 0 00000000 00000000 0 0 00000000 1 80000100 01
ecall_flt   08 05 00000000 00000000 01 2 1 0 00000000 00000000 0 0 00000000 1 80000100 0b
csr_err_flt 10 10 00000000 00000300 01 2 1 0 00000000 00000000 1 0 00000000 1 80000100 02

//--- sources.f
src/wb_cfg_pkg.sv
src/wb_isa_pkg.sv
src/wb_stage_if.sv
src/wb_flow_ctrl.sv
src/wb_load_unit.sv
src/wb_csr_unit.sv
src/wb_gpr_arbiter.sv
src/wb_top.sv
bench/wb_flow_chk.sv
bench/wb_tb.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  - src/wb_cfg_pkg.sv
  - src/wb_isa_pkg.sv
  - src/wb_stage_if.sv
  - src/wb_flow_ctrl.sv
  - src/wb_load_unit.sv
  - src/wb_csr_unit.sv
  - src/wb_gpr_arbiter.sv
  - src/wb_top.sv
  - target: test
    files:
      - bench/wb_flow_chk.sv
      - bench/wb_tb.sv

//--- bench/wb_tb.sv
// Writeback stage testbench
`timescale 1ns/1ps

module wb_tb
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
();

    localparam int    CLK_PERIOD = 4;
    localparam word_t MEPC       = 32'h8000_1000; // Fixed CSR file values
    localparam word_t MTVEC      = 32'h8000_0100;

    // DUT signals
    // ------------------------------
    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       s4_valid, s4_trap, s4_busy;
    fu_t        s4_fu;
    uop_t       s4_uop;
    word_t      s4_opr_a, s4_opr_b;
    reg_addr_t  s4_rd, gpr_rd;
    logic [1:0] s4_size;
    logic       gpr_wen, csr_en, csr_wr, csr_wr_set, csr_wr_clr, csr_error;
    word_t      gpr_wdata, csr_wdata, csr_rdata, csr_mepc, csr_mtvec, cf_target;
    csr_addr_t  csr_addr;
    logic       cf_req, cf_ack, trap_cpu, exec_mret, hold_lsu_req, trs_valid;
    cause_t     trap_cause;
    word_t      trap_mtval, trap_pc, trs_pc, dmem_rdata;
    logic       dmem_req, dmem_gnt, dmem_error;

    // One stimulus line
    string      name;
    logic [4:0] fu, uop, rd;
    uop_t       uop_v;     // Same micro-op, read through its views
    word_t      opr_a, opr_b, d_rdata, c_rdata, exp_wdata, exp_target;
    logic [1:0] size;
    logic       trap, d_err, c_err, exp_wen, exp_cf;
    cause_t     exp_cause;

    // Bench state
    integer     fd, c, r, delay, cycles;
    integer     n_wen, n_csr, n_trs, n_mret;
    integer     n_lines = 0;
    integer     tests   = 0;
    integer     errors  = 0;
    integer     asrt_fails;
    integer     seed    = 32'h9b58;
    logic       lines_counted = 1'b0;
    word_t      pc_model, exp_wd, exp_mtval;
    logic       cf_first, is_mret;

    wb_top DUT (.*);

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    task automatic report_mismatch(input string what, input word_t expv, input word_t actv);
        errors++;
        $display("error %s %s expected %h actual %h", name, what, expv, actv);
    endtask

    // Per cycle observation, taken at the falling edge
    task automatic sample_cycle();
        if (gpr_wen) begin
            n_wen++;
            if (gpr_wdata !== exp_wd) report_mismatch("gpr_wdata", exp_wd, gpr_wdata);
            if (gpr_rd !== rd) report_mismatch("gpr_rd", rd, gpr_rd);
        end
        if (csr_en) begin
            n_csr++;
            if (csr_addr !== opr_b[11:0]) report_mismatch("csr_addr", opr_b[11:0], csr_addr);
            if (csr_wdata !== opr_a) report_mismatch("csr_wdata", opr_a, csr_wdata);
        end
        // Write kind flags only for CSR instructions
        if (csr_wr !== (fu[FU_CSR] && uop_v.csr.write))
            report_mismatch("csr_wr", fu[FU_CSR] && uop_v.csr.write, csr_wr);
        if (csr_wr_set !== (fu[FU_CSR] && uop_v.csr.set))
            report_mismatch("csr_wr_set", fu[FU_CSR] && uop_v.csr.set, csr_wr_set);
        if (csr_wr_clr !== (fu[FU_CSR] && uop_v.csr.clear))
            report_mismatch("csr_wr_clr", fu[FU_CSR] && uop_v.csr.clear, csr_wr_clr);
        if (exec_mret) n_mret++;
        if (trs_valid) begin
            n_trs++;
            if (trs_pc !== pc_model) report_mismatch("trs_pc", pc_model, trs_pc);
        end
        // Memory held for the whole flow change
        if (hold_lsu_req !== exp_cf) report_mismatch("hold_lsu_req", exp_cf, hold_lsu_req);
        if (cf_req) begin
            if (cf_target !== exp_target) report_mismatch("cf_target", exp_target, cf_target);
            if (trap_cpu !== (exp_cause != 0)) report_mismatch("trap_cpu", exp_cause != 0, trap_cpu);
            if (exp_cause != 0 && trap_cause !== exp_cause)
                report_mismatch("trap_cause", exp_cause, trap_cause);
            if (exp_cause != 0 && trap_mtval !== exp_mtval)
                report_mismatch("trap_mtval", exp_mtval, trap_mtval);
            if (exp_cause != 0 && trap_pc !== pc_model)
                report_mismatch("trap_pc", pc_model, trap_pc);
        end
    endtask

    // One instruction from issue to retire, then one idle cycle
    task automatic run_line();
        tests++;
        delay     = $unsigned($random(seed)) % 4; // cf_ack latency
        exp_wd    = fu[FU_CFU] ? pc_model + {size, 1'b0} : exp_wdata; // Link is next PC
        exp_mtval = (exp_cause >= TRAP_LDALIGN && exp_cause <= TRAP_STACCESS) ? opr_b : '0;
        is_mret   = fu[FU_CFU] && uop == CFU_MRET;
        uop_v     = uop;
        n_wen     = 0;
        n_csr     = 0;
        n_trs     = 0;
        n_mret    = 0;
        cycles    = 0;
        @(posedge g_clk);
        if (fu[FU_LSU]) begin                 // Grant one cycle ahead
            dmem_req   <= 1'b1;
            dmem_gnt   <= 1'b1;
            dmem_error <= d_err;
            dmem_rdata <= d_rdata;
            @(posedge g_clk);
            dmem_req   <= 1'b0;
            dmem_gnt   <= 1'b0;
        end
        s4_valid  <= 1'b1;
        s4_fu     <= fu;
        s4_uop    <= uop;
        s4_opr_a  <= opr_a;
        s4_opr_b  <= opr_b;
        s4_rd     <= rd;
        s4_size   <= size;
        s4_trap   <= trap;
        csr_rdata <= c_rdata;
        csr_error <= c_err;
        cf_ack    <= (delay == 0);
        @(negedge g_clk);
        cf_first = cf_req;
        sample_cycle();
        while (s4_busy) begin                 // Stalled on the flow change
            cycles++;
            @(posedge g_clk);
            cf_ack <= (cycles >= delay);
            @(negedge g_clk);
            sample_cycle();
        end
        if (n_wen !== exp_wen) report_mismatch("gpr_wen_count", exp_wen, n_wen);
        if (cf_first !== exp_cf) report_mismatch("cf_req", exp_cf, cf_first);
        if (cycles != (exp_cf ? delay : 0))
            report_mismatch("busy_cycles", exp_cf ? delay : 0, cycles);
        if (n_trs != 1) report_mismatch("trs_valid_count", 1, n_trs);
        if (n_csr != fu[FU_CSR]) report_mismatch("csr_en_count", fu[FU_CSR], n_csr);
        if (n_mret != is_mret) report_mismatch("exec_mret_count", is_mret, n_mret);
        pc_model = exp_cf ? exp_target : pc_model + {size, 1'b0};
        @(posedge g_clk);
        s4_valid   <= 1'b0;
        s4_fu      <= '0;                     // Unit field zero while idle
        s4_trap    <= 1'b0;
        cf_ack     <= 1'b0;
        dmem_error <= 1'b0;
        csr_error  <= 1'b0;
        @(negedge g_clk);
        if ((cf_req | hold_lsu_req | gpr_wen | csr_en | trs_valid | exec_mret | s4_busy)
            !== 1'b0) begin
            $display("%s left outputs active with the stage idle", name);
            errors++;
        end
    endtask

    // Watchdog sized by the stimulus length
    initial begin
        wait (lines_counted);
        #(n_lines * 10 * CLK_PERIOD);
        $display("timeout after %0d ns with the stimulus unfinished", n_lines * 10 * CLK_PERIOD);
        $display("TB FAILED");
        $finish;
    end

    // Main sequence
    // ------------------------------
    initial begin
        g_resetn   = 1'b0;
        s4_valid   = 1'b0;
        s4_fu      = '0;
        s4_uop     = '0;
        s4_opr_a   = '0;
        s4_opr_b   = '0;
        s4_rd      = '0;
        s4_size    = '0;
        s4_trap    = 1'b0;
        csr_rdata  = '0;
        csr_error  = 1'b0;
        csr_mepc   = MEPC;
        csr_mtvec  = MTVEC;
        cf_ack     = 1'b0;
        dmem_req   = 1'b0;
        dmem_gnt   = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        name       = "reset";
        fd = $fopen("bench/wb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/wb_stim.txt");
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin             // Count lines for the watchdog
                if (c == 10) n_lines++;
                c = $fgetc(fd);
            end
            lines_counted = 1'b1;
            $fclose(fd);
            fd = $fopen("bench/wb_stim.txt", "r");
            repeat (3) @(posedge g_clk);
            g_resetn <= 1'b1;
            @(negedge g_clk);
            if (trs_pc !== PC_RESET) report_mismatch("reset_pc", PC_RESET, trs_pc);
            pc_model = PC_RESET;
            while ($fscanf(fd, " %s", name) == 1) begin
                if (name[0] == "#") begin     // Comment line
                    c = $fgetc(fd);
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end else begin
                    r = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fu, uop, opr_a, opr_b, rd, size, trap, d_err, d_rdata,
                                c_rdata, c_err, exp_wen, exp_wdata, exp_cf, exp_target,
                                exp_cause);
                    if (r != 16) begin
                        $display("stimulus line %s is malformed", name);
                        errors++;
                    end else begin
                        run_line();
                    end
                end
            end
            $fclose(fd);
        end
        asrt_fails = DUT.u_flow_chk.fails;
        $display("tests %0d errors %0d assertion failures %0d", tests, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- bench/wb_flow_chk.sv
// Writeback flow assertions
`timescale 1ns/1ps

module wb_flow_chk
    import wb_cfg_pkg::*;
(
    input logic  g_clk,
    input logic  g_resetn,
    input logic  s4_valid,
    input logic  s4_busy,
    input logic  cf_req,
    input logic  cf_ack,
    input word_t cf_target,
    input logic  exec_mret,
    input logic  gpr_wen
);

    int unsigned fails = 0; // Failed assertion count

    wire progress = s4_valid && !s4_busy; // Instruction retires

    // Request and target hold until the ack cycle
    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else begin
            fails++;
            $error("cf_req dropped or cf_target moved before cf_ack");
        end

    // MRET leaves only on the flow handshake
    a_mret_prog: assert property (@(posedge g_clk) disable iff (!g_resetn)
        exec_mret |-> progress && cf_req && cf_ack)
        else begin
            fails++;
            $error("exec_mret outside the cf_ack cycle");
        end

    // Stalled instruction never writes twice
    a_one_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        gpr_wen && s4_busy |=> !gpr_wen)
        else begin
            fails++;
            $error("second gpr_wen within one instruction");
        end

endmodule

bind wb_top wb_flow_chk u_flow_chk (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .s4_valid  (s4_valid),
    .s4_busy   (s4_busy),
    .cf_req    (cf_req),
    .cf_ack    (cf_ack),
    .cf_target (cf_target),
    .exec_mret (exec_mret),
    .gpr_wen   (gpr_wen)
);

//--- src/wb_top.sv
// Writeback stage top level
`timescale 1ns/1ps

module wb_top
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,

    input  logic       s4_valid,     // Stage inputs valid
    input  fu_t        s4_fu,
    input  uop_t       s4_uop,
    input  word_t      s4_opr_a,
    input  word_t      s4_opr_b,
    input  reg_addr_t  s4_rd,
    input  logic [1:0] s4_size,
    input  logic       s4_trap,
    output logic       s4_busy,      // Stall the previous stage

    output logic       gpr_wen,      // Register file write port
    output reg_addr_t  gpr_rd,
    output word_t      gpr_wdata,

    output logic       csr_en,       // CSR access
    output logic       csr_wr,
    output logic       csr_wr_set,
    output logic       csr_wr_clr,
    output csr_addr_t  csr_addr,
    output word_t      csr_wdata,
    input  word_t      csr_rdata,
    input  logic       csr_error,
    input  word_t      csr_mepc,
    input  word_t      csr_mtvec,

    output logic       cf_req,       // Control flow change
    output word_t      cf_target,
    input  logic       cf_ack,

    output logic       trap_cpu,
    output cause_t     trap_cause,
    output word_t      trap_mtval,
    output word_t      trap_pc,

    output logic       exec_mret,
    output logic       hold_lsu_req, // No new LSU requests yet
    output word_t      trs_pc,       // Trace
    output logic       trs_valid,

    input  logic       dmem_req,     // Data memory
    input  logic       dmem_gnt,
    input  logic       dmem_error,
    input  word_t      dmem_rdata
);

    // Peer to peer wires
    logic  lsu_trap, lsu_load, lsu_store;
    logic  csr_trap;
    logic  load_wen, csr_wen, link_wen;
    word_t load_wdata, csr_wres, link_wdata;

    wb_stage_if stage ();

    // Pipeline inputs into the bundle
    // ------------------------------
    assign stage.valid = s4_valid;
    assign stage.fu    = s4_fu;
    assign stage.uop   = s4_uop;
    assign stage.opr_a = s4_opr_a;
    assign stage.opr_b = s4_opr_b;
    assign stage.rd    = s4_rd;
    assign stage.size  = s4_size;
    assign stage.trap  = s4_trap;
    assign s4_busy     = stage.busy;

    assign hold_lsu_req = cf_req; // Memory waits for the flow change

    wb_flow_ctrl u_flow (
        .g_clk, .g_resetn, .stage(stage),
        .lsu_trap, .lsu_load, .lsu_store, .csr_trap,
        .csr_mepc, .csr_mtvec, .cf_ack,
        .cf_req, .cf_target, .exec_mret,
        .trap_cpu, .trap_cause, .trap_mtval, .trap_pc,
        .trs_pc, .trs_valid, .link_wen, .link_wdata
    );

    wb_load_unit u_load (
        .g_clk, .g_resetn, .stage(stage),
        .dmem_req, .dmem_gnt, .dmem_error, .dmem_rdata,
        .load_wen, .load_wdata, .lsu_trap, .lsu_load, .lsu_store
    );

    wb_csr_unit u_csr (
        .g_clk, .g_resetn, .stage(stage),
        .csr_rdata, .csr_error,
        .csr_en, .csr_wr, .csr_wr_set, .csr_wr_clr, .csr_addr, .csr_wdata,
        .csr_wen, .csr_wres, .csr_trap
    );

    wb_gpr_arbiter u_arb (
        .g_clk, .g_resetn, .stage(stage),
        .load_wen, .load_wdata, .csr_wen, .csr_wres, .link_wen, .link_wdata,
        .gpr_wen, .gpr_rd, .gpr_wdata
    );

endmodule

//--- src/wb_gpr_arbiter.sv
// Writeback register file port arbiter
`timescale 1ns/1ps

module wb_gpr_arbiter
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_stage_if.unit   stage,

    input  logic       load_wen,
    input  word_t      load_wdata,
    input  logic       csr_wen,
    input  word_t      csr_wres,
    input  logic       link_wen,
    input  word_t      link_wdata,

    output logic       gpr_wen,
    output reg_addr_t  gpr_rd,
    output word_t      gpr_wdata
);

    logic wr_done; // Instruction already wrote rd

    // ALU and multiply results arrive in operand A
    wire opa_wen = stage.fu[FU_ALU] || stage.fu[FU_MUL];

    always_ff @(posedge g_clk) begin
        if (!g_resetn || stage.progress) begin
            wr_done <= 1'b0;
        end else if (gpr_wen) begin
            wr_done <= 1'b1;
        end
    end

    assign gpr_rd    = stage.rd;
    assign gpr_wen   = !(stage.valid && stage.trap) && !wr_done &&
                       (opa_wen || load_wen || csr_wen || link_wen);

    // One-hot unit field keeps the sources exclusive
    assign gpr_wdata = {XLEN{opa_wen }} & stage.opr_a |
                       {XLEN{load_wen}} & load_wdata  |
                       {XLEN{csr_wen }} & csr_wres    |
                       {XLEN{link_wen}} & link_wdata;

endmodule

//--- src/wb_csr_unit.sv
// Writeback CSR access
`timescale 1ns/1ps

module wb_csr_unit
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_stage_if.unit   stage,

    input  word_t      csr_rdata,
    input  logic       csr_error,

    output logic       csr_en,     // First cycle only
    output logic       csr_wr,
    output logic       csr_wr_set,
    output logic       csr_wr_clr,
    output csr_addr_t  csr_addr,
    output word_t      csr_wdata,
    output logic       csr_wen,    // Read result to the arbiter
    output word_t      csr_wres,
    output logic       csr_trap
);

    logic csr_done; // Access already issued

    wire fu_csr = stage.fu[FU_CSR];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !stage.progress && (csr_done || csr_en);
        end
    end

    assign csr_en     = fu_csr && !csr_done;
    assign csr_wr     = fu_csr && stage.uop.csr.write;
    assign csr_wr_set = fu_csr && stage.uop.csr.set;
    assign csr_wr_clr = fu_csr && stage.uop.csr.clear;
    assign csr_addr   = stage.opr_b[11:0];
    assign csr_wdata  = stage.opr_a;

    assign csr_trap   = fu_csr && csr_error; // Illegal opcode trap
    assign csr_wen    = fu_csr && stage.uop.csr.read && !csr_done && !csr_error;
    assign csr_wres   = csr_rdata;

endmodule

//--- src/wb_load_unit.sv
// Writeback load data and bus errors
`timescale 1ns/1ps

module wb_load_unit
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_stage_if.unit   stage,

    input  logic       dmem_req,
    input  logic       dmem_gnt,
    input  logic       dmem_error,
    input  word_t      dmem_rdata,

    output logic       load_wen,
    output word_t      load_wdata,
    output logic       lsu_trap,  // Bus error on this access
    output logic       lsu_load,
    output logic       lsu_store
);

    logic dmem_rsp;   // Response due this cycle
    logic err_q;      // Sticky bus error

    // Response tracking
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            dmem_rsp <= 1'b0;
        end else begin
            dmem_rsp <= dmem_req && dmem_gnt; // Granted last cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || stage.progress) begin
            err_q <= 1'b0;
        end else if (dmem_rsp) begin
            err_q <= dmem_error;
        end
    end

    wire fu_lsu = stage.fu[FU_LSU];
    wire bus_err = dmem_rsp && dmem_error || err_q;

    assign lsu_load  = fu_lsu && stage.uop.lsu.load;
    assign lsu_store = fu_lsu && stage.uop.lsu.store;
    assign lsu_trap  = fu_lsu && bus_err;

    // Byte alignment
    // ------------------------------
    wire [1:0] ofs   = stage.opr_b[1:0]; // Address low bits
    wire [3:0] strb  = stage.opr_a[3:0]; // Byte strobes from memory stage
    wire is_byte = stage.uop.lsu.size == LSU_BYTE;
    wire is_half = stage.uop.lsu.size == LSU_HALF;
    wire is_word = stage.uop.lsu.size == LSU_WORD;
    wire sgn     = stage.uop.lsu.sgn;

    wire [7:0] b0 = {8{strb[0]}}                          & dmem_rdata[7:0]   |
                    {8{is_byte && ofs == 2'd1}}           & dmem_rdata[15:8]  |
                    {8{is_byte && ofs == 2'd2 ||
                       is_half && ofs[1]}}                & dmem_rdata[23:16] |
                    {8{is_byte && ofs == 2'd3}}           & dmem_rdata[31:24];

    wire [7:0] b1 = {8{is_byte && sgn}}                   & {8{b0[7]}}        |
                    {8{is_half && !ofs[1] || is_word}}    & dmem_rdata[15:8]  |
                    {8{is_half && ofs[1]}}                & dmem_rdata[31:24];

    // Upper half is extension or word data
    wire [15:0] h1 = {16{(is_byte || is_half) && sgn}}    & {16{b1[7]}}       |
                     {16{is_word}}                        & dmem_rdata[31:16];

    assign load_wdata = {h1, b1, b0};
    assign load_wen   = lsu_load && !bus_err; // No write on a bus error

endmodule

//--- src/wb_flow_ctrl.sv
// Writeback control flow and trap control
`timescale 1ns/1ps

module wb_flow_ctrl
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_stage_if.flow   stage,

    input  logic       lsu_trap,   // Load or store bus error
    input  logic       lsu_load,
    input  logic       lsu_store,
    input  logic       csr_trap,   // Bad CSR access
    input  word_t      csr_mepc,
    input  word_t      csr_mtvec,
    input  logic       cf_ack,

    output logic       cf_req,
    output word_t      cf_target,
    output logic       exec_mret,
    output logic       trap_cpu,
    output cause_t     trap_cause,
    output word_t      trap_mtval,
    output word_t      trap_pc,
    output word_t      trs_pc,
    output logic       trs_valid,
    output logic       link_wen,   // Jump link value to the arbiter
    output word_t      link_wdata
);

    logic  cfu_done;   // Flow change handled, still stalled
    word_t n_pc;       // Natural next PC

    // Stage PC
    // ------------------------------
    assign n_pc = stage.pc + word_t'({stage.size, 1'b0});

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            stage.pc <= PC_RESET;
        end else if (cf_req && cf_ack) begin
            stage.pc <= cf_target; // Jump or trap taken
        end else if (stage.progress) begin
            stage.pc <= n_pc;
        end
    end

    // CFU decode
    // ------------------------------
    wire fu_cfu     = stage.fu[FU_CFU];
    wire cfu_jump   = fu_cfu && (stage.uop.cfu == CFU_JALI ||
                                 stage.uop.cfu == CFU_JALR);
    wire cfu_taken  = cfu_jump || fu_cfu && stage.uop.cfu == CFU_TAKEN;
    wire cfu_ebreak = fu_cfu && stage.uop.cfu == CFU_EBREAK;
    wire cfu_ecall  = fu_cfu && stage.uop.cfu == CFU_ECALL;
    wire cfu_mret   = fu_cfu && stage.uop.cfu == CFU_MRET;
    wire cfu_trap   = cfu_ebreak || cfu_ecall;

    wire fault      = stage.valid && stage.trap; // Earlier stage fault

    // Anything that ends at the trap vector
    wire tgt_trap   = cfu_trap || fault || lsu_trap || csr_trap;

    assign cf_req    = cfu_taken || cfu_mret || tgt_trap;
    assign cf_target = tgt_trap ? csr_mtvec :
                       {XLEN{cfu_taken}} & stage.opr_a |
                       {XLEN{cfu_mret }} & csr_mepc;

    wire cf_fin     = cf_req && cf_ack; // Handshake this cycle

    // Stall and done
    // ------------------------------
    wire cfu_busy = fu_cfu && !(cfu_done || cf_fin) &&
                    (cfu_taken || cfu_trap || cfu_mret);

    assign stage.busy     = cfu_busy || (cf_req && !cf_ack);
    assign stage.progress = stage.valid && !stage.busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !stage.progress && (cfu_done || cf_fin);
        end
    end

    assign exec_mret  = cfu_mret && stage.progress; // One pulse to the CSRs

    assign link_wen   = cfu_jump;
    assign link_wdata = n_pc; // Return address

    // Trap reporting
    // ------------------------------
    wire addr_align = fault && ({1'b0, stage.rd} == TRAP_LDALIGN ||
                                {1'b0, stage.rd} == TRAP_STALIGN);

    assign trap_cpu   = tgt_trap;
    assign trap_cause = lsu_trap && lsu_load  ? TRAP_LDACCESS :
                        lsu_trap && lsu_store ? TRAP_STACCESS :
                        cfu_ebreak            ? TRAP_BREAKPT  :
                        cfu_ecall             ? TRAP_ECALLM   :
                        csr_trap              ? TRAP_IOPCODE  :
                                                {1'b0, stage.rd}; // Fault code
    assign trap_mtval = (lsu_trap || addr_align) ? stage.opr_b : '0;
    assign trap_pc    = stage.pc;

    // Trace one packet per retired instruction
    assign trs_pc    = stage.pc;
    assign trs_valid = |stage.size &&
                       (stage.progress || (cf_fin && !cfu_done));

endmodule

//--- src/wb_stage_if.sv
// Writeback stage instruction bundle
`timescale 1ns/1ps

interface wb_stage_if
    import wb_cfg_pkg::*;
    import wb_isa_pkg::*;
();

    logic      valid;    // Stage holds an instruction
    logic      busy;     // Stage cannot accept the next one
    logic      progress; // Instruction leaves this cycle
    fu_t       fu;       // Zero when not valid
    uop_t      uop;
    word_t     opr_a;    // Result or strobes or target
    word_t     opr_b;    // Address or CSR number
    reg_addr_t rd;       // Also fault cause when trap is set
    logic [1:0] size;    // Instruction size in halfwords
    logic      trap;     // Fault from an earlier stage
    word_t     pc;       // Stage PC

    // Inputs from the pipeline
    modport top  (output valid, fu, uop, opr_a, opr_b, rd, size, trap,
                  input  busy, progress, pc);

    // Stage owner
    modport flow (input  valid, fu, uop, opr_a, opr_b, rd, size, trap,
                  output busy, progress, pc);

    // Result producers
    modport unit (input  valid, busy, progress, fu, uop, opr_a, opr_b, rd,
                         size, trap, pc);

endinterface

//--- src/wb_isa_pkg.sv
// Writeback stage ISA encodings
package wb_isa_pkg;

    import wb_cfg_pkg::*;

    // Functional unit one-hot positions
    // ------------------------------
    localparam int unsigned FU_ALU = 0;
    localparam int unsigned FU_MUL = 1;
    localparam int unsigned FU_LSU = 2;
    localparam int unsigned FU_CFU = 3;
    localparam int unsigned FU_CSR = 4;

    typedef logic [4:0] fu_t; // One bit per unit

    // Control flow unit codes
    // ------------------------------
    localparam logic [4:0] CFU_TAKEN  = 5'b00001; // Taken branch
    localparam logic [4:0] CFU_JALI   = 5'b00010; // Direct jump and link
    localparam logic [4:0] CFU_JALR   = 5'b00011; // Indirect jump and link
    localparam logic [4:0] CFU_EBREAK = 5'b00100;
    localparam logic [4:0] CFU_ECALL  = 5'b00101;
    localparam logic [4:0] CFU_MRET   = 5'b00110;

    // Access size field
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Machine trap causes
    // ------------------------------
    localparam cause_t TRAP_IOPCODE  = 6'd2;  // Illegal instruction
    localparam cause_t TRAP_BREAKPT  = 6'd3;
    localparam cause_t TRAP_LDALIGN  = 6'd4;
    localparam cause_t TRAP_LDACCESS = 6'd5;
    localparam cause_t TRAP_STALIGN  = 6'd6;
    localparam cause_t TRAP_STACCESS = 6'd7;
    localparam cause_t TRAP_ECALLM   = 6'd11; // ECALL from M mode

    // Micro-op word views
    // ------------------------------
    typedef struct packed {
        logic       store; // Bit 4
        logic       load;  // Bit 3
        logic [1:0] size;  // Byte, half or word
        logic       sgn;   // Sign extend the result
    } lsu_uop_t;

    typedef struct packed {
        logic read;  // Bit 4
        logic write; // Plain write
        logic set;   // Bit set write
        logic clear; // Bit clear write
        logic spare;
    } csr_uop_t;

    // Same 5 bits, read per unit
    typedef union packed {
        lsu_uop_t   lsu;
        csr_uop_t   csr;
        logic [4:0] cfu;
    } uop_t;

endpackage

//--- src/wb_cfg_pkg.sv
// Writeback stage configuration
package wb_cfg_pkg;

    // Datapath
    // ------------------------------
    localparam int unsigned XLEN = 32;                    // Data width

    localparam logic [XLEN-1:0] PC_RESET = 32'h8000_0000; // PC after reset

    // Common word types
    // ------------------------------
    typedef logic [XLEN-1:0] word_t;     // One data word
    typedef logic [4:0]      reg_addr_t; // GPR index
    typedef logic [11:0]     csr_addr_t; // CSR address
    typedef logic [5:0]      cause_t;    // mcause code

endpackage
